/* hdl/rv_isa_pkg.sv */
package rv_isa_pkg;

    localparam int xlen = 32;
    localparam int ilen = 32;
    localparam int reg_addr_w = 5;
    localparam int nreg = 1 << reg_addr_w;

    localparam logic [xlen-1:0] reset_pc = '0;

    // funct3 codes of the kept instructions
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll = 3'b001;
    localparam logic [2:0] f3_slt = 3'b010;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_srl = 3'b101;
    localparam logic [2:0] f3_or = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;
    localparam logic [2:0] f3_word = 3'b010;
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;

    typedef enum logic [6:0] {
        op_r = 7'b0110011,
        op_imm = 7'b0010011,
        op_lui = 7'b0110111,
        op_load = 7'b0000011,
        op_store = 7'b0100011,
        op_branch = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_and = 4'd2,
        alu_or = 4'd3,
        alu_xor = 4'd4,
        alu_slt = 4'd5,
        alu_sll = 4'd6,
        alu_srl = 4'd7,
        alu_pass_b = 4'd8
    } alu_op_e;

endpackage

/* hdl/rv_pipe_pkg.sv */
package rv_pipe_pkg;

    import rv_isa_pkg::*;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [ilen-1:0] instr;
    } if_id_t;

    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       rs1_val;
        logic [xlen-1:0]       rs2_val;
        logic [xlen-1:0]       imm;
        alu_op_e               alu_op;
        logic                  use_imm;
        logic                  reg_write;
        logic                  mem_read;
        logic                  mem_write;
        logic                  is_branch;
        logic                  branch_ne;
    } id_ex_t;

    typedef struct packed {
        logic                  valid;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       result;
        logic [xlen-1:0]       store_data;
        logic                  reg_write;
        logic                  mem_read;
        logic                  mem_write;
    } ex_mem_t;

    typedef struct packed {
        logic                  valid;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       wdata;
        logic                  reg_write;
    } mem_wb_t;

endpackage

/* hdl/rv_fetch.sv */
`timescale 1ns/100ps

module rv_fetch import rv_isa_pkg::*, rv_pipe_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            stall,
    input  logic            freeze,
    input  logic            flush,
    input  logic [xlen-1:0] branch_target,
    output logic [xlen-1:0] imem_addr,
    input  logic [ilen-1:0] imem_data,
    output if_id_t          if_id
);

    logic [xlen-1:0] pc;

    assign imem_addr = pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= reset_pc;
            if_id.valid <= 1'b0;
        end else if (!freeze) begin
            if (flush) begin
                // Redirect and drop the wrong-path fetch
                pc <= branch_target;
                if_id.valid <= 1'b0;
            end else if (!stall) begin
                pc <= pc + xlen'(4);
                if_id.valid <= 1'b1;
                if_id.pc <= pc;
                if_id.instr <= imem_data;
            end
        end
    end

endmodule

/* hdl/rv_decode.sv */
`timescale 1ns/100ps

module rv_decode import rv_isa_pkg::*, rv_pipe_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    stall,
    input  logic    freeze,
    input  logic    flush,
    input  if_id_t  if_id,
    input  mem_wb_t mem_wb,
    output id_ex_t  id_ex
);

    logic [xlen-1:0] regs [nreg];
    logic [ilen-1:0] instr;
    opcode_e op;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic legal;
    logic wb_en;
    id_ex_t dec;

    assign instr = if_id.instr;
    assign op = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd = instr[11:7];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    assign wb_en = mem_wb.valid && mem_wb.reg_write && (mem_wb.rd != '0);

    // Write-through from the register being written this cycle
    function automatic logic [xlen-1:0] read_reg(input logic [reg_addr_w-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (wb_en && mem_wb.rd == addr) begin
            return mem_wb.wdata;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < nreg; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[mem_wb.rd] <= mem_wb.wdata;
        end
    end

    always_comb begin
        dec = '0;
        legal = 1'b1;
        dec.pc = if_id.pc;
        dec.rs1 = rs1;
        dec.rs2 = rs2;
        dec.rd = rd;
        dec.rs1_val = read_reg(rs1);
        dec.rs2_val = read_reg(rs2);
        dec.alu_op = alu_add;
        case (op)
            op_r: begin
                dec.reg_write = 1'b1;
                case (funct3)
                    f3_add_sub: dec.alu_op = funct7[5] ? alu_sub : alu_add;
                    f3_sll: dec.alu_op = alu_sll;
                    f3_slt: dec.alu_op = alu_slt;
                    f3_xor: dec.alu_op = alu_xor;
                    f3_srl: begin
                        // SRA is not kept
                        dec.alu_op = alu_srl;
                        legal = !funct7[5];
                    end
                    f3_or: dec.alu_op = alu_or;
                    f3_and: dec.alu_op = alu_and;
                    default: legal = 1'b0;
                endcase
            end
            op_imm: begin
                dec.reg_write = 1'b1;
                dec.use_imm = 1'b1;
                dec.imm = imm_i;
                case (funct3)
                    f3_add_sub: dec.alu_op = alu_add;
                    f3_slt: dec.alu_op = alu_slt;
                    f3_xor: dec.alu_op = alu_xor;
                    f3_or: dec.alu_op = alu_or;
                    f3_and: dec.alu_op = alu_and;
                    default: legal = 1'b0;
                endcase
            end
            op_lui: begin
                dec.reg_write = 1'b1;
                dec.use_imm = 1'b1;
                dec.imm = imm_u;
                dec.alu_op = alu_pass_b;
            end
            op_load: begin
                dec.reg_write = 1'b1;
                dec.mem_read = 1'b1;
                dec.use_imm = 1'b1;
                dec.imm = imm_i;
                legal = (funct3 == f3_word);
            end
            op_store: begin
                dec.mem_write = 1'b1;
                dec.use_imm = 1'b1;
                dec.imm = imm_s;
                legal = (funct3 == f3_word);
            end
            op_branch: begin
                dec.is_branch = 1'b1;
                dec.imm = imm_b;
                dec.branch_ne = (funct3 == f3_bne);
                legal = (funct3 == f3_beq) || (funct3 == f3_bne);
            end
            default: legal = 1'b0;
        endcase
        // Anything else retires as a no-op
        if (!legal) begin
            dec.reg_write = 1'b0;
            dec.mem_read = 1'b0;
            dec.mem_write = 1'b0;
            dec.is_branch = 1'b0;
        end
        dec.valid = if_id.valid && !stall && !flush;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_ex.valid <= 1'b0;
        end else if (!freeze) begin
            id_ex <= dec;
        end
    end

endmodule

/* hdl/rv_execute.sv */
`timescale 1ns/100ps

module rv_execute import rv_isa_pkg::*, rv_pipe_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            freeze,
    input  id_ex_t          id_ex,
    input  mem_wb_t         mem_wb,
    output ex_mem_t         ex_mem,
    output logic            branch_taken,
    output logic [xlen-1:0] branch_target
);

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] result;

    // Newest producer wins
    function automatic logic [xlen-1:0] pick_operand(input logic [reg_addr_w-1:0] rs,
                                                     input logic [xlen-1:0] reg_val);
        if (rs == '0) begin
            return reg_val;
        end
        if (ex_mem.valid && ex_mem.reg_write && ex_mem.rd == rs) begin
            return ex_mem.result;
        end
        if (mem_wb.valid && mem_wb.reg_write && mem_wb.rd == rs) begin
            return mem_wb.wdata;
        end
        return reg_val;
    endfunction

    always_comb begin
        op_a = pick_operand(id_ex.rs1, id_ex.rs1_val);
        op_b = pick_operand(id_ex.rs2, id_ex.rs2_val);
        alu_b = id_ex.use_imm ? id_ex.imm : op_b;
        case (id_ex.alu_op)
            alu_add: result = op_a + alu_b;
            alu_sub: result = op_a - alu_b;
            alu_and: result = op_a & alu_b;
            alu_or: result = op_a | alu_b;
            alu_xor: result = op_a ^ alu_b;
            alu_slt: result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
            alu_sll: result = op_a << alu_b[$clog2(xlen)-1:0];
            alu_srl: result = op_a >> alu_b[$clog2(xlen)-1:0];
            alu_pass_b: result = alu_b;
            default: result = '0;
        endcase
    end

    assign branch_taken = id_ex.valid && id_ex.is_branch && ((op_a == op_b) != id_ex.branch_ne);
    assign branch_target = id_ex.pc + id_ex.imm;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_mem.valid <= 1'b0;
        end else if (!freeze) begin
            ex_mem.valid <= id_ex.valid;
            ex_mem.rd <= id_ex.rd;
            ex_mem.result <= result;
            ex_mem.store_data <= op_b;
            ex_mem.reg_write <= id_ex.reg_write;
            ex_mem.mem_read <= id_ex.mem_read;
            ex_mem.mem_write <= id_ex.mem_write;
        end
    end

endmodule

/* hdl/rv_memory.sv */
`timescale 1ns/100ps

module rv_memory import rv_isa_pkg::*, rv_pipe_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  ex_mem_t         ex_mem,
    output logic            mem_busy,
    output mem_wb_t         mem_wb,
    output logic            psel,
    output logic            penable,
    output logic            pwrite,
    output logic [xlen-1:0] paddr,
    output logic [xlen-1:0] pwdata,
    input  logic [xlen-1:0] prdata,
    input  logic            pready
);

    typedef enum logic [1:0] {
        st_idle,
        st_setup,
        st_access
    } apb_state_e;

    apb_state_e state;
    apb_state_e phase;
    logic mem_op;
    logic done;

    assign mem_op = ex_mem.valid && (ex_mem.mem_read || ex_mem.mem_write);

    // Setup starts in the cycle the access enters MEM
    always_comb begin
        if (state == st_access) begin
            phase = st_access;
        end else if (mem_op) begin
            phase = st_setup;
        end else begin
            phase = st_idle;
        end
    end

    assign done = (phase == st_access) && pready;
    assign mem_busy = mem_op && !done;

    assign psel = (phase != st_idle);
    assign penable = (phase == st_access);
    assign pwrite = ex_mem.valid && ex_mem.mem_write;
    // EX/MEM is frozen until completion, so these hold
    assign paddr = ex_mem.result;
    assign pwdata = ex_mem.store_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (phase)
                st_setup: state <= st_access;
                st_access: state <= pready ? st_idle : st_access;
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_wb.valid <= 1'b0;
        end else if (!mem_busy) begin
            mem_wb.valid <= ex_mem.valid;
            mem_wb.rd <= ex_mem.rd;
            mem_wb.reg_write <= ex_mem.reg_write;
            mem_wb.wdata <= ex_mem.mem_read ? prdata : ex_mem.result;
        end
    end

endmodule

/* hdl/rv_hazard.sv */
`timescale 1ns/100ps

module rv_hazard import rv_isa_pkg::*, rv_pipe_pkg::*; (
    input  if_id_t if_id,
    input  id_ex_t id_ex,
    input  logic   mem_busy,
    input  logic   branch_taken,
    output logic   stall,
    output logic   freeze,
    output logic   flush
);

    opcode_e op;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic uses_rs1;
    logic uses_rs2;
    logic load_use;

    assign op = opcode_e'(if_id.instr[6:0]);
    assign rs1 = if_id.instr[19:15];
    assign rs2 = if_id.instr[24:20];

    // Only real sources count, LUI reads nothing
    assign uses_rs1 = op inside {op_r, op_imm, op_load, op_store, op_branch};
    assign uses_rs2 = op inside {op_r, op_store, op_branch};

    assign load_use = if_id.valid && id_ex.valid && id_ex.mem_read && (id_ex.rd != '0)
                      && ((uses_rs1 && rs1 == id_ex.rd) || (uses_rs2 && rs2 == id_ex.rd));

    assign freeze = mem_busy;
    assign stall = load_use && !freeze;
    assign flush = branch_taken && !freeze;

endmodule

/* hdl/rv_core.sv */
`timescale 1ns/100ps

module rv_core import rv_isa_pkg::*, rv_pipe_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,

    // Instruction port
    output logic [xlen-1:0] imem_addr,
    input  logic [ilen-1:0] imem_data,

    // APB data port
    output logic            psel,
    output logic            penable,
    output logic            pwrite,
    output logic [xlen-1:0] paddr,
    output logic [xlen-1:0] pwdata,
    input  logic [xlen-1:0] prdata,
    input  logic            pready
);

    if_id_t if_id;
    id_ex_t id_ex;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;

    logic stall;
    logic freeze;
    logic flush;
    logic branch_taken;
    logic [xlen-1:0] branch_target;
    logic mem_busy;

    rv_fetch fetch_inst (
        .clk(clk),
        .rst_n(rst_n),
        .stall(stall),
        .freeze(freeze),
        .flush(flush),
        .branch_target(branch_target),
        .imem_addr(imem_addr),
        .imem_data(imem_data),
        .if_id(if_id)
    );

    rv_decode decode_inst (
        .clk(clk),
        .rst_n(rst_n),
        .stall(stall),
        .freeze(freeze),
        .flush(flush),
        .if_id(if_id),
        .mem_wb(mem_wb),
        .id_ex(id_ex)
    );

    rv_execute execute_inst (
        .clk(clk),
        .rst_n(rst_n),
        .freeze(freeze),
        .id_ex(id_ex),
        .mem_wb(mem_wb),
        .ex_mem(ex_mem),
        .branch_taken(branch_taken),
        .branch_target(branch_target)
    );

    rv_memory memory_inst (
        .clk(clk),
        .rst_n(rst_n),
        .ex_mem(ex_mem),
        .mem_busy(mem_busy),
        .mem_wb(mem_wb),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready)
    );

    rv_hazard hazard_inst (
        .if_id(if_id),
        .id_ex(id_ex),
        .mem_busy(mem_busy),
        .branch_taken(branch_taken),
        .stall(stall),
        .freeze(freeze),
        .flush(flush)
    );

endmodule

/* test/rv_core_assert.sv */
`timescale 1ns/100ps

module rv_core_assert import rv_isa_pkg::*; (
    input logic            clk,
    input logic            rst_n,
    input logic            psel,
    input logic            penable,
    input logic            pwrite,
    input logic [xlen-1:0] paddr,
    input logic [xlen-1:0] pwdata,
    input logic            pready
);

    // Access phase only after a setup phase
    penable_after_setup: assert property (
        @(posedge clk) disable iff (!rst_n)
        penable && !$past(penable) |-> psel && $past(psel)
    ) else $error("penable rose without a preceding setup cycle");

    // Address and data hold until pready completes the transfer
    stable_while_waiting: assert property (
        @(posedge clk) disable iff (!rst_n)
        psel && !(penable && pready) |=> $stable(paddr) && $stable(pwrite) && $stable(pwdata)
    ) else $error("APB address, direction or write data changed during a transfer");

    idle_in_reset: assert property (
        @(posedge clk)
        !rst_n && $past(!rst_n) |-> !psel && !penable
    ) else $error("APB select or enable high during reset");

endmodule

bind rv_core rv_core_assert apb_checks (
    .clk(clk),
    .rst_n(rst_n),
    .psel(psel),
    .penable(penable),
    .pwrite(pwrite),
    .paddr(paddr),
    .pwdata(pwdata),
    .pready(pready)
);

/* test/rv_core_tb.sv */
`timescale 1ns/100ps

module rv_core_tb;

    localparam int rom_words = 64;
    localparam int body_words = 56;
    localparam int mem_words = 64;
    localparam int timeout_cycles = 2000;
    localparam int watch_cycles = 20;
    localparam logic [31:0] nop_instr = 32'h0000_0013;
    localparam logic [31:0] loop_pc = 32'(4 * (rom_words - 1));

    // Major opcodes of RV32I
    localparam logic [6:0] opc_r = 7'h33;
    localparam logic [6:0] opc_imm = 7'h13;
    localparam logic [6:0] opc_lui = 7'h37;
    localparam logic [6:0] opc_load = 7'h03;
    localparam logic [6:0] opc_store = 7'h23;
    localparam logic [6:0] opc_branch = 7'h63;

    logic clk;
    logic rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic psel;
    logic penable;
    logic pwrite;
    logic [31:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;

    logic [31:0] rom [rom_words];
    logic [31:0] slave_mem [mem_words];
    logic [31:0] model_mem [mem_words];
    logic [31:0] model_regs [32];
    int wait_table [256];

    logic [31:0] exp_store_addr [$];
    logic [31:0] exp_store_data [$];
    logic [31:0] exp_load_addr [$];

    integer seed;
    int errors;
    int apb_errors;
    int writes_seen;
    int reads_seen;
    int access_idx;
    int wait_left;

    // Fetches past the end of the ROM see a NOP
    assign imem_data = (imem_addr[31:2] < 30'(rom_words)) ? rom[imem_addr[7:2]] : nop_instr;

    rv_core dut0 (
        .clk(clk),
        .rst_n(rst_n),
        .imem_addr(imem_addr),
        .imem_data(imem_data),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return int'({1'b0, r[30:0]} % n);
    endfunction

    function automatic logic [4:0] pick_reg();
        return 5'(1 + rand_below(7));
    endfunction

    function automatic logic [31:0] fill_word(input int idx);
        return 32'h9e37_79b9 * 32'(idx + 1);
    endfunction

    function automatic logic [31:0] store_word(input logic [4:0] rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, 5'd0, 3'd2, imm[4:0], opc_store};
    endfunction

    function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1,
                                                input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opc_branch};
    endfunction

    task automatic build_program();
        int kind;
        int span;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        for (int i = 0; i < body_words; i++) begin
            kind = rand_below(16);
            rd = pick_reg();
            rs1 = pick_reg();
            rs2 = pick_reg();
            if (kind < 5) begin
                f3 = 3'(rand_below(8));
                // No SLTU in the kept set
                if (f3 == 3'd3) begin
                    f3 = 3'd7;
                end
                f7 = 7'h00;
                if (f3 == 3'd0 && rand_below(2) == 1) begin
                    f7 = 7'h20;
                end
                rom[i] = {f7, rs2, rs1, f3, rd, opc_r};
            end else if (kind < 8) begin
                case (rand_below(5))
                    0: f3 = 3'd0;
                    1: f3 = 3'd2;
                    2: f3 = 3'd4;
                    3: f3 = 3'd6;
                    default: f3 = 3'd7;
                endcase
                rom[i] = {12'(rand_below(4096)), rs1, f3, rd, opc_imm};
            end else if (kind < 9) begin
                rom[i] = {20'(rand_below(1 << 20)), rd, opc_lui};
            end else if (kind < 12) begin
                rom[i] = {12'(4 * rand_below(mem_words)), 5'd0, 3'd2, rd, opc_load};
            end else if (kind < 14) begin
                rom[i] = store_word(rs2, 12'(4 * rand_below(mem_words)));
            end else begin
                span = 1 + rand_below(3);
                if (i + span > body_words) begin
                    span = body_words - i;
                end
                f3 = 3'(rand_below(2));
                rom[i] = branch_word(f3, 5'(rand_below(8)), 5'(rand_below(8)), 13'(4 * span));
            end
        end
        // Epilogue dumps x1..x7, then spins
        for (int j = 1; j < 8; j++) begin
            rom[body_words + j - 1] = store_word(5'(j), 12'(4 * (body_words + j - 1)));
        end
        rom[rom_words - 1] = branch_word(3'd0, 5'd0, 5'd0, 13'd0);
    endtask

    task automatic run_model();
        logic [31:0] pc;
        logic [31:0] pc_next;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] addr;
        logic [31:0] res;
        logic [4:0] rd;
        logic [2:0] f3;
        logic wr;
        int steps;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 32'h0;
        end
        pc = 32'h0;
        steps = 0;
        while (pc != loop_pc && steps < 1000) begin
            ins = rom[pc[7:2]];
            rd = ins[11:7];
            f3 = ins[14:12];
            a = model_regs[ins[19:15]];
            b = model_regs[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            wr = 1'b0;
            res = 32'h0;
            pc_next = pc + 32'd4;
            case (ins[6:0])
                opc_r: begin
                    wr = 1'b1;
                    case (f3)
                        3'd0: res = ins[30] ? a - b : a + b;
                        3'd1: res = a << b[4:0];
                        3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        3'd4: res = a ^ b;
                        3'd5: res = a >> b[4:0];
                        3'd6: res = a | b;
                        3'd7: res = a & b;
                        default: wr = 1'b0;
                    endcase
                end
                opc_imm: begin
                    wr = 1'b1;
                    case (f3)
                        3'd0: res = a + imm_i;
                        3'd2: res = ($signed(a) < $signed(imm_i)) ? 32'd1 : 32'd0;
                        3'd4: res = a ^ imm_i;
                        3'd6: res = a | imm_i;
                        3'd7: res = a & imm_i;
                        default: wr = 1'b0;
                    endcase
                end
                opc_lui: begin
                    wr = 1'b1;
                    res = {ins[31:12], 12'h000};
                end
                opc_load: begin
                    wr = 1'b1;
                    addr = a + imm_i;
                    exp_load_addr.push_back(addr);
                    res = model_mem[addr[7:2]];
                end
                opc_store: begin
                    addr = a + imm_s;
                    exp_store_addr.push_back(addr);
                    exp_store_data.push_back(b);
                    model_mem[addr[7:2]] = b;
                end
                opc_branch: begin
                    if ((f3 == 3'd0 && a == b) || (f3 == 3'd1 && a != b)) begin
                        pc_next = pc + imm_b;
                    end
                end
                default: ;
            endcase
            if (wr && rd != 5'd0) begin
                model_regs[rd] = res;
            end
            pc = pc_next;
            steps++;
        end
        if (pc != loop_pc) begin
            errors++;
            $display("Error: reference model never reached the self-loop");
        end
    endtask

    task automatic complete_transfer();
        if (pwrite) begin
            if (writes_seen >= exp_store_addr.size()) begin
                apb_errors++;
                $display("Error at %0d ns: APB write to %h was not expected", $time, paddr);
            end else begin
                if (paddr !== exp_store_addr[writes_seen]) begin
                    apb_errors++;
                    $display("Mismatch at %0d ns: paddr expected %h got %h",
                             $time, exp_store_addr[writes_seen], paddr);
                end
                if (pwdata !== exp_store_data[writes_seen]) begin
                    apb_errors++;
                    $display("Mismatch at %0d ns: pwdata expected %h got %h",
                             $time, exp_store_data[writes_seen], pwdata);
                end
            end
            slave_mem[paddr[7:2]] = pwdata;
            writes_seen++;
        end else begin
            if (reads_seen >= exp_load_addr.size()) begin
                apb_errors++;
                $display("Error at %0d ns: APB read from %h was not expected", $time, paddr);
            end else if (paddr !== exp_load_addr[reads_seen]) begin
                apb_errors++;
                $display("Mismatch at %0d ns: paddr expected %h got %h",
                         $time, exp_load_addr[reads_seen], paddr);
            end
            reads_seen++;
        end
    endtask

    task automatic drive_slave();
        if (psel && !penable) begin
            wait_left = wait_table[access_idx % 256];
            access_idx++;
            pready = 1'b0;
        end else if (psel && penable && wait_left > 0) begin
            wait_left--;
            pready = 1'b0;
        end else begin
            pready = psel && penable;
        end
        prdata = psel ? slave_mem[paddr[7:2]] : 32'h0;
    endtask

    // APB slave memory with random wait states
    initial begin
        pready = 1'b0;
        prdata = 32'h0;
        apb_errors = 0;
        writes_seen = 0;
        reads_seen = 0;
        access_idx = 0;
        wait_left = 0;
        for (int i = 0; i < mem_words; i++) begin
            slave_mem[i] = fill_word(i);
        end
        forever begin
            @(posedge clk);
            #1;
            drive_slave();
            @(negedge clk);
            if (rst_n && psel && penable && pready) begin
                complete_transfer();
            end
        end
    end

    task automatic wait_for_epilogue();
        int cycles;
        cycles = 0;
        while ((writes_seen < exp_store_addr.size() || reads_seen < exp_load_addr.size())
               && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
        end
        if (writes_seen < exp_store_addr.size() || reads_seen < exp_load_addr.size()) begin
            errors++;
            $display("Error: timeout after %0d cycles, the epilogue stores never arrived",
                     timeout_cycles);
        end
    endtask

    task automatic watch_self_loop();
        for (int i = 0; i < watch_cycles; i++) begin
            @(negedge clk);
            if (imem_addr < loop_pc || imem_addr > loop_pc + 32'd8) begin
                errors++;
                $display("Error at %0d ns: imem_addr %h left the self-loop at %h",
                         $time, imem_addr, loop_pc);
            end
        end
    endtask

    initial begin
        seed = 32'h63dc_a643;
        errors = 0;
        rst_n = 1'b0;
        for (int i = 0; i < mem_words; i++) begin
            model_mem[i] = fill_word(i);
        end
        build_program();
        run_model();
        for (int i = 0; i < 256; i++) begin
            wait_table[i] = rand_below(4);
        end
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
        wait_for_epilogue();
        watch_self_loop();
        if (writes_seen != exp_store_addr.size()) begin
            errors++;
            $display("Error: %0d APB writes completed, the model expects %0d",
                     writes_seen, exp_store_addr.size());
        end
        if (reads_seen != exp_load_addr.size()) begin
            errors++;
            $display("Error: %0d APB reads completed, the model expects %0d",
                     reads_seen, exp_load_addr.size());
        end
        $display("Errors: %0d (checks %0d, APB %0d)", errors + apb_errors, errors, apb_errors);
        if (errors + apb_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* sim.f */
hdl/rv_isa_pkg.sv
hdl/rv_pipe_pkg.sv
hdl/rv_fetch.sv
hdl/rv_decode.sv
hdl/rv_execute.sv
hdl/rv_memory.sv
hdl/rv_hazard.sv
hdl/rv_core.sv
test/rv_core_assert.sv
test/rv_core_tb.sv

/* run.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module rv_core_tb -f sim.f -o rv_core_sim \
    && ./obj_dir/rv_core_sim > sim.log 2>&1
[ -f sim.log ] && cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1
grep -q "PASS: all tests" sim.log || exit 1
exit 0
